//--- project.f
rtl/mips_pkg.sv
rtl/lwl_test_rom.sv
rtl/cpu_control_fsm.sv
rtl/bus_watchdog.sv
rtl/reg_file.sv
rtl/load_store_unit.sv
rtl/mips_datapath.sv
rtl/mips_lwl_top.sv
testbench/mips_lwl_properties.sv
testbench/tb_mips_lwl.sv

//--- run_verilator.sh
#!/bin/sh
# build, run, and decide on the pass line in the output
verilator --binary --timing --assert -f project.f --top-module tb_mips_lwl -o tb_mips_lwl \
    && ./obj_dir/tb_mips_lwl | tee /dev/stderr | grep -q "^TB PASSED$" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- testbench/tb_mips_lwl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mips_lwl;

    localparam int ROWS       = 6;
    localparam int HALT_LIMIT = 400;
    localparam int QUIET      = 20;

    logic        clk      = 1'b0;
    logic        arst_n   = 1'b0;
    logic [31:0] wb_dat_r = 32'd0;
    logic        wb_ack   = 1'b0;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [31:0] wb_adr;
    logic [31:0] wb_dat_w;
    logic [3:0]  wb_sel;
    logic        active;
    logic        bus_error;
    logic [31:0] register_v0;
    logic [31:0] cycle_count;

    // stimulus and expected values, one row per program run
    logic [31:0] row_word0   [ROWS];
    logic [31:0] row_word100 [ROWS];
    int          row_waits   [ROWS];
    bit          row_hold    [ROWS];
    int          row_stores  [ROWS];
    logic [31:0] exp_r2      [ROWS];
    logic [31:0] exp_r3      [ROWS];
    logic [31:0] exp_v0      [ROWS];

    // settings of the row under test, read by the memory model
    logic [31:0] cur_word0   = 32'd0;
    logic [31:0] cur_word100 = 32'd0;
    int          cur_waits   = 0;
    bit          cur_hold    = 1'b0;

    // memory model state and its bus log
    logic [31:0] mem [0:31];
    logic [4:0]  mem_idx;
    logic        in_cycle;
    int          wait_cnt;
    logic [31:0] held_adr;
    logic [31:0] held_dat;
    int          cyc_starts;
    int          write_starts;
    logic [31:0] rec_adr [$];
    logic        rec_we  [$];
    logic [3:0]  rec_sel [$];
    logic [31:0] rec_dat [$];

    logic [31:0] rng_state = 32'hf5c99c76;
    int          value_errors  = 0;
    int          stable_errors = 0;
    int          timeouts      = 0;

    mips_lwl_top #(
        .ROM_WORDS   (4096),
        .BUS_TIMEOUT (64)
    ) UUT (
        .clk         (clk),
        .arst_n      (arst_n),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_sel      (wb_sel),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .active      (active),
        .bus_error   (bus_error),
        .register_v0 (register_v0),
        .cycle_count (cycle_count)
    );

    initial begin
        forever begin
            #5 clk = ~clk;
        end
    end

    // wishbone slave, acts on the falling edge
    // ack comes after cur_waits wait states, or never on a held row
    always @(negedge clk) begin
        if (!arst_n) begin
            // fill depends on the whole byte address
            for (int i = 0; i < 32; i++) begin
                mem[i] = 32'hC3A5_0000 ^ (32'(i) << 2);
            end
            mem[0]       = cur_word0;
            mem[25]      = cur_word100;
            wb_ack       = 1'b0;
            in_cycle     = 1'b0;
            wait_cnt     = 0;
            cyc_starts   = 0;
            write_starts = 0;
            rec_adr.delete();
            rec_we.delete();
            rec_sel.delete();
            rec_dat.delete();
        end else if (wb_ack) begin
            // single-cycle ack, cyc has dropped by now
            wb_ack   = 1'b0;
            in_cycle = 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (!in_cycle) begin
                in_cycle = 1'b1;
                wait_cnt = 0;
                held_adr = wb_adr;
                held_dat = wb_dat_w;
                cyc_starts++;
                if (wb_we) begin
                    write_starts++;
                end
            end else begin
                assert (wb_adr === held_adr && wb_dat_w === held_dat) else begin
                    stable_errors++;
                    $display("bus address or write data changed while waiting for ack");
                end
            end
            if (!cur_hold && wait_cnt >= cur_waits) begin
                mem_idx = wb_adr[6:2];
                rec_adr.push_back(wb_adr);
                rec_we.push_back(wb_we);
                rec_sel.push_back(wb_sel);
                if (wb_we) begin
                    mem[mem_idx] = wb_dat_w;
                    rec_dat.push_back(wb_dat_w);
                end else begin
                    wb_dat_r = mem[mem_idx];
                    rec_dat.push_back(mem[mem_idx]);
                end
                wb_ack = 1'b1;
            end else begin
                wait_cnt++;
            end
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // big-endian lwl, k = addr mod 4
    // memory word moved up 8k bits, old rt fills the low 8k bits
    function automatic logic [31:0] lwl_rule(
        input logic [31:0] word,
        input logic [31:0] old,
        input logic [31:0] addr
    );
        int          sh;
        logic [31:0] keep_mask;
        sh        = 8 * int'(addr % 32'd4);
        keep_mask = ~(32'hFFFF_FFFF << sh);
        return (word << sh) | (old & keep_mask);
    endfunction

    // bus cycles of a complete run, in program order
    function automatic logic [31:0] expected_address(input int i);
        case (i)
            0:       return 32'd0;
            1:       return 32'd100;
            2:       return 32'd16;
            default: return 32'd20;
        endcase
    endfunction

    task automatic check_value(
        input string       name,
        input logic [31:0] expected,
        input logic [31:0] actual
    );
        assert (actual === expected) else begin
            value_errors++;
            $display("Fail %s: expected %08h, actual %08h", name, expected, actual);
        end
    endtask

    task automatic init_table();
        // two fixed rows, then four from the generator
        row_word0[0]   = 32'h1234_BBBB;
        row_word100[0] = 32'h89AB_CDEF;
        row_waits[0]   = 0;
        row_hold[0]    = 1'b0;
        row_word0[1]   = 32'h1234_BBBB;
        row_word100[1] = 32'h00C0_FFEE;
        row_waits[1]   = 5;
        row_hold[1]    = 1'b0;
        for (int r = 2; r < ROWS; r++) begin
            rng_state      = xorshift32(rng_state);
            row_word0[r]   = rng_state;
            rng_state      = xorshift32(rng_state);
            row_word100[r] = rng_state;
            rng_state      = xorshift32(rng_state);
            row_waits[r]   = int'(rng_state % 32'd6);
            // last row never gets an ack
            row_hold[r]    = (r == ROWS - 1);
        end
        for (int r = 0; r < ROWS; r++) begin
            // r2 and r3 as the addiu instructions leave them
            exp_r2[r]     = lwl_rule(row_word0[r], 32'hFFFF_FFFF, 32'd2);
            exp_r3[r]     = lwl_rule(row_word100[r], 32'hFFFF_8CB3, 32'd100);
            exp_v0[r]     = row_hold[r] ? 32'hFFFF_FFFF : exp_r2[r];
            row_stores[r] = row_hold[r] ? 0 : 2;
        end
    endtask

    // entered one rising edge after release
    // counts rising edges up to the halt and notes the first edge with bus_error set
    task automatic wait_for_halt(
        input  string tag,
        output int    edges,
        output int    error_edge
    );
        int n;
        n          = 0;
        error_edge = -1;
        while (active && n < HALT_LIMIT) begin
            @(negedge clk);
            n++;
            if (bus_error && error_edge < 0) begin
                error_edge = n + 1;
            end
        end
        edges = n + 1;
        if (active) begin
            timeouts++;
            $display("%s: core still active after %0d cycles, it never halted", tag, HALT_LIMIT);
        end
    endtask

    task automatic run_row(input int r);
        int    starts_at_halt;
        int    halt_edges;
        int    error_edge;
        int    exp_cycles;
        string tag;
        tag = $sformatf("row %0d", r);
        @(negedge clk);
        arst_n      = 1'b0;
        cur_word0   = row_word0[r];
        cur_word100 = row_word100[r];
        cur_waits   = row_waits[r];
        cur_hold    = row_hold[r];
        repeat (10) @(negedge clk);
        check_value({tag, " reset wb_cyc"}, 32'd0, 32'(wb_cyc));
        check_value({tag, " reset wb_stb"}, 32'd0, 32'(wb_stb));
        check_value({tag, " reset bus_error"}, 32'd0, 32'(bus_error));
        arst_n = 1'b1;
        // one rising edge later the core is running
        @(negedge clk);
        check_value({tag, " active after reset"}, 32'd1, 32'(active));
        wait_for_halt(tag, halt_edges, error_edge);
        // the bus must stay idle once halted
        starts_at_halt = cyc_starts;
        repeat (QUIET) @(negedge clk);
        check_value({tag, " bus cycles after halt"}, starts_at_halt, cyc_starts);
        check_value({tag, " wb_cyc after halt"}, 32'd0, 32'(wb_cyc));
        check_value({tag, " active after halt"}, 32'd0, 32'(active));
        check_value({tag, " register_v0"}, exp_v0[r], register_v0);
        check_value({tag, " bus_error"}, 32'(row_hold[r]), 32'(bus_error));
        check_value({tag, " write cycles"}, row_stores[r], write_starts);
        // one count per rising edge since release, stopped on the bus_error edge
        exp_cycles = row_hold[r] ? error_edge : halt_edges + QUIET;
        check_value({tag, " cycle_count"}, 32'(exp_cycles), cycle_count);
        if (row_hold[r]) begin
            // only the first lwl read started, and it timed out
            check_value({tag, " acked cycles"}, 32'd0, rec_adr.size());
            check_value({tag, " started cycles"}, 32'd1, cyc_starts);
        end else begin
            check_value({tag, " acked cycles"}, 32'd4, rec_adr.size());
            if (rec_adr.size() == 4) begin
                for (int i = 0; i < 4; i++) begin
                    check_value($sformatf("%s cycle %0d address", tag, i),
                                expected_address(i), rec_adr[i]);
                    check_value($sformatf("%s cycle %0d we", tag, i),
                                32'(i >= 2), 32'(rec_we[i]));
                    check_value($sformatf("%s cycle %0d sel", tag, i),
                                32'hF, 32'(rec_sel[i]));
                end
                check_value({tag, " store r2"}, exp_r2[r], rec_dat[2]);
                check_value({tag, " store r3"}, exp_r3[r], rec_dat[3]);
            end
        end
    endtask

    initial begin
        init_table();
        // the rule itself, against the known fixed-row result
        check_value("lwl rule reference", 32'hBBBB_FFFF, exp_r2[0]);
        for (int r = 0; r < ROWS; r++) begin
            run_row(r);
        end
        $display("errors: %0d value, %0d bus stability, %0d timeout",
                 value_errors, stable_errors, timeouts);
        if (value_errors == 0 && stable_errors == 0 && timeouts == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/mips_lwl_properties.sv
`timescale 1ns/1ps
`default_nettype none

module mips_lwl_properties (
    input logic        clk,
    input logic        arst_n,
    input logic        wb_cyc,
    input logic        wb_stb,
    input logic        wb_ack,
    input logic [31:0] wb_adr,
    input logic        active,
    input logic        bus_error
);

    // strobe only inside a bus cycle
    stb_in_cyc: assert property (@(posedge clk) disable iff (!arst_n)
        wb_stb |-> wb_cyc)
        else $error("wb_stb high without wb_cyc");

    // address held until the slave acks
    adr_stable: assert property (@(posedge clk) disable iff (!arst_n)
        (wb_stb && !wb_ack) |=> (!wb_stb || $stable(wb_adr)))
        else $error("wb_adr changed during a pending cycle");

    // a halted core leaves the bus alone
    idle_bus: assert property (@(posedge clk) disable iff (!arst_n)
        !active |-> !wb_cyc)
        else $error("wb_cyc high while core inactive");

    // timeout stops the core
    error_halts: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(bus_error) |-> ##2 !active)
        else $error("core still active after bus_error");

endmodule

bind mips_lwl_top mips_lwl_properties u_props (
    .clk       (clk),
    .arst_n    (arst_n),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_ack    (wb_ack),
    .wb_adr    (wb_adr),
    .active    (active),
    .bus_error (bus_error)
);

`default_nettype wire

//--- rtl/mips_lwl_top.sv
`timescale 1ns/1ps
`default_nettype none

module mips_lwl_top #(
    parameter int ROM_WORDS   = 4096,
    parameter int BUS_TIMEOUT = 64
) (
    input  logic        clk,
    input  logic        arst_n,
    output logic        wb_cyc,
    output logic        wb_stb,
    output logic        wb_we,
    output logic [31:0] wb_adr,
    output logic [31:0] wb_dat_w,
    output logic [3:0]  wb_sel,
    input  logic [31:0] wb_dat_r,
    input  logic        wb_ack,
    output logic        active,
    output logic        bus_error,
    output logic [31:0] register_v0,
    output logic [31:0] cycle_count
);

    mips_pkg::opcode_t opcode;
    mips_pkg::funct_t  funct;

    logic [31:0] instr_address;
    logic [31:0] instr_readdata;
    logic        ir_load;
    logic        pc_advance;
    logic        reg_write;
    logic        reg_write_sel;
    logic        mem_start;
    logic        mem_write;
    logic        mem_done;
    logic        halted;
    logic        jump_pending_zero;

    assign active = !halted;

    cpu_control_fsm u_fsm (
        .clk               (clk),
        .arst_n            (arst_n),
        .opcode            (opcode),
        .funct             (funct),
        .mem_done          (mem_done),
        .bus_error         (bus_error),
        .jump_pending_zero (jump_pending_zero),
        .ir_load           (ir_load),
        .pc_advance        (pc_advance),
        .reg_write         (reg_write),
        .reg_write_sel     (reg_write_sel),
        .mem_start         (mem_start),
        .mem_write         (mem_write),
        .halted            (halted)
    );

    bus_watchdog #(
        .BUS_TIMEOUT (BUS_TIMEOUT)
    ) u_watchdog (
        .clk         (clk),
        .arst_n      (arst_n),
        .wb_cyc      (wb_cyc),
        .wb_ack      (wb_ack),
        .bus_error   (bus_error),
        .cycle_count (cycle_count)
    );

    mips_datapath u_datapath (
        .clk               (clk),
        .arst_n            (arst_n),
        .ir_load           (ir_load),
        .pc_advance        (pc_advance),
        .reg_write         (reg_write),
        .reg_write_sel     (reg_write_sel),
        .mem_start         (mem_start),
        .mem_write         (mem_write),
        .halted            (halted),
        .instr_readdata    (instr_readdata),
        .instr_address     (instr_address),
        .opcode            (opcode),
        .funct             (funct),
        .jump_pending_zero (jump_pending_zero),
        .wb_cyc            (wb_cyc),
        .wb_stb            (wb_stb),
        .wb_we             (wb_we),
        .wb_adr            (wb_adr),
        .wb_dat_w          (wb_dat_w),
        .wb_sel            (wb_sel),
        .wb_dat_r          (wb_dat_r),
        .wb_ack            (wb_ack),
        .mem_done          (mem_done),
        .register_v0       (register_v0)
    );

    lwl_test_rom #(
        .ROM_WORDS (ROM_WORDS)
    ) u_rom (
        .instr_address  (instr_address),
        .instr_readdata (instr_readdata)
    );

endmodule

`default_nettype wire

//--- rtl/mips_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module mips_datapath (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              ir_load,
    input  logic              pc_advance,
    input  logic              reg_write,
    input  logic              reg_write_sel,
    input  logic              mem_start,
    input  logic              mem_write,
    input  logic              halted,
    input  logic [31:0]       instr_readdata,
    output logic [31:0]       instr_address,
    output mips_pkg::opcode_t opcode,
    output mips_pkg::funct_t  funct,
    output logic              jump_pending_zero,
    output logic              wb_cyc,
    output logic              wb_stb,
    output logic              wb_we,
    output logic [31:0]       wb_adr,
    output logic [31:0]       wb_dat_w,
    output logic [3:0]        wb_sel,
    input  logic [31:0]       wb_dat_r,
    input  logic              wb_ack,
    output logic              mem_done,
    output logic [31:0]       register_v0
);

    logic [31:0] pc;
    logic [31:0] ir;
    logic [31:0] jump_target;
    logic        jump_pending;
    logic [31:0] rs_data;
    logic [31:0] rt_data;
    logic [31:0] imm_sext;
    logic [31:0] addiu_sum;
    logic [31:0] wr_data;
    logic [31:0] load_result;
    logic        is_jr;
    logic        is_lwl;
    logic        lsu_cyc;
    logic        lsu_stb;

    assign instr_address = pc;
    assign opcode        = mips_pkg::opcode_t'(ir[31:26]);
    assign funct         = mips_pkg::funct_t'(ir[5:0]);
    assign is_jr         = (opcode == mips_pkg::OP_SPECIAL) && (funct == mips_pkg::FN_JR);
    assign is_lwl        = (opcode == mips_pkg::OP_LWL);

    // addiu: rs plus sign-extended immediate
    assign imm_sext  = {{16{ir[15]}}, ir[15:0]};
    assign addiu_sum = rs_data + imm_sext;
    assign wr_data   = reg_write_sel ? load_result : addiu_sum;

    // jr 0 is the program's end marker
    assign jump_pending_zero = jump_pending && (jump_target == 32'd0);

    // pc moves when an instruction retires
    // a jr arms the target, the delay slot's retirement takes it
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc           <= mips_pkg::RESET_VECTOR;
            ir           <= 32'd0;
            jump_pending <= 1'b0;
        end else begin
            if (ir_load) begin
                ir <= instr_readdata;
            end
            if (pc_advance) begin
                pc           <= jump_pending ? jump_target : pc + 32'd4;
                jump_pending <= is_jr;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pc_advance && is_jr) begin
            jump_target <= rs_data;
        end
    end

    reg_file u_reg_file (
        .clk         (clk),
        .arst_n      (arst_n),
        .rs_addr     (ir[25:21]),
        .rt_addr     (ir[20:16]),
        .wr_addr     (ir[20:16]),
        .wr_en       (reg_write),
        .wr_data     (wr_data),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .register_v0 (register_v0)
    );

    load_store_unit u_lsu (
        .clk         (clk),
        .arst_n      (arst_n),
        .mem_start   (mem_start),
        .mem_write   (mem_write),
        .is_lwl      (is_lwl),
        .base        (rs_data),
        .offset      (ir[15:0]),
        .rt_old      (rt_data),
        .wb_cyc      (lsu_cyc),
        .wb_stb      (lsu_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_sel      (wb_sel),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .mem_done    (mem_done),
        .load_result (load_result)
    );

    // a halted core abandons a timed-out cycle
    assign wb_cyc = lsu_cyc && !halted;
    assign wb_stb = lsu_stb && !halted;

endmodule

`default_nettype wire

//--- rtl/load_store_unit.sv
`timescale 1ns/1ps
`default_nettype none

module load_store_unit (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        mem_start,
    input  logic        mem_write,
    input  logic        is_lwl,
    input  logic [31:0] base,
    input  logic [15:0] offset,
    input  logic [31:0] rt_old,
    output logic        wb_cyc,
    output logic        wb_stb,
    output logic        wb_we,
    output logic [31:0] wb_adr,
    output logic [31:0] wb_dat_w,
    output logic [3:0]  wb_sel,
    input  logic [31:0] wb_dat_r,
    input  logic        wb_ack,
    output logic        mem_done,
    output logic [31:0] load_result
);

    logic [31:0] eff_addr;
    logic [1:0]  byte_off;
    logic        lwl_q;
    logic [31:0] rdata_q;
    logic        cyc_q;

    assign eff_addr = base + {{16{offset[15]}}, offset};

    // cyc and stb rise together and drop on the edge after ack
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cyc_q <= 1'b0;
            wb_we <= 1'b0;
        end else if (mem_start) begin
            cyc_q <= 1'b1;
            wb_we <= mem_write;
        end else if (cyc_q && wb_ack) begin
            cyc_q <= 1'b0;
            wb_we <= 1'b0;
        end
    end

    // address and store data held for the whole cycle
    always_ff @(posedge clk) begin
        if (mem_start) begin
            wb_adr   <= {eff_addr[31:2], 2'b00};
            wb_dat_w <= rt_old;
            byte_off <= eff_addr[1:0];
            lwl_q    <= is_lwl;
        end
        if (cyc_q && wb_ack) begin
            rdata_q <= wb_dat_r;
        end
    end

    assign wb_cyc   = cyc_q;
    assign wb_stb   = cyc_q;
    // whole words only
    assign wb_sel   = 4'b1111;
    assign mem_done = cyc_q && wb_ack;

    // big-endian lwl
    // word shifted up by 8k bits, low 8k bits kept from rt
    always_comb begin
        if (!lwl_q) begin
            load_result = rdata_q;
        end else begin
            case (byte_off)
                2'd0:    load_result = rdata_q;
                2'd1:    load_result = {rdata_q[23:0], rt_old[7:0]};
                2'd2:    load_result = {rdata_q[15:0], rt_old[15:0]};
                default: load_result = {rdata_q[7:0], rt_old[23:0]};
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [4:0]  rs_addr,
    input  logic [4:0]  rt_addr,
    input  logic [4:0]  wr_addr,
    input  logic        wr_en,
    input  logic [31:0] wr_data,
    output logic [31:0] rs_data,
    output logic [31:0] rt_data,
    output logic [31:0] register_v0
);

    logic [31:0] regs [0:31];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (wr_en && (wr_addr != mips_pkg::REG_ZERO)) begin
            // r0 never leaves zero
            regs[wr_addr] <= wr_data;
        end
    end

    // asynchronous read ports
    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];

    // v0 brought out for observation
    assign register_v0 = regs[mips_pkg::REG_V0];

endmodule

`default_nettype wire

//--- rtl/bus_watchdog.sv
`timescale 1ns/1ps
`default_nettype none

module bus_watchdog #(
    parameter int BUS_TIMEOUT = 64
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        wb_cyc,
    input  logic        wb_ack,
    output logic        bus_error,
    output logic [31:0] cycle_count
);

    localparam int CNT_BITS = $clog2(BUS_TIMEOUT + 1);

    logic [CNT_BITS-1:0] wait_count;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wait_count  <= '0;
            bus_error   <= 1'b0;
            cycle_count <= 32'd0;
        end else begin
            // wait states of the current cycle, cleared between cycles
            if (wb_cyc && !wb_ack) begin
                if (wait_count == CNT_BITS'(BUS_TIMEOUT - 1)) begin
                    // sticky until reset
                    bus_error <= 1'b1;
                end else begin
                    wait_count <= wait_count + 1'b1;
                end
            end else begin
                wait_count <= '0;
            end
            // run length, frozen at the timeout
            if (!bus_error) begin
                cycle_count <= cycle_count + 32'd1;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/cpu_control_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_control_fsm (
    input  logic              clk,
    input  logic              arst_n,
    input  mips_pkg::opcode_t opcode,
    input  mips_pkg::funct_t  funct,
    input  logic              mem_done,
    input  logic              bus_error,
    input  logic              jump_pending_zero,
    output logic              ir_load,
    output logic              pc_advance,
    output logic              reg_write,
    output logic              reg_write_sel,
    output logic              mem_start,
    output logic              mem_write,
    output logic              halted
);

    mips_pkg::cpu_state_t state;
    mips_pkg::cpu_state_t state_next;
    mips_pkg::cpu_state_t done_state;

    logic is_load;
    logic is_store;
    logic is_imm;
    logic is_jump;

    // instruction classes
    assign is_load  = (opcode == mips_pkg::OP_LW) || (opcode == mips_pkg::OP_LWL);
    assign is_store = (opcode == mips_pkg::OP_SW);
    assign is_imm   = (opcode == mips_pkg::OP_ADDIU);
    assign is_jump  = (opcode == mips_pkg::OP_SPECIAL) && (funct == mips_pkg::FN_JR);

    // where an instruction goes when it retires
    // a pending jr to 0 stops the core once its delay slot is done
    assign done_state = jump_pending_zero ? mips_pkg::ST_HALT : mips_pkg::ST_FETCH;

    always_comb begin
        ir_load       = 1'b0;
        pc_advance    = 1'b0;
        reg_write     = 1'b0;
        reg_write_sel = 1'b0;
        mem_start     = 1'b0;
        mem_write     = 1'b0;
        state_next    = state;
        case (state)
            mips_pkg::ST_FETCH: begin
                ir_load    = 1'b1;
                state_next = mips_pkg::ST_EXEC;
            end
            mips_pkg::ST_EXEC: begin
                if (is_load || is_store) begin
                    mem_start  = 1'b1;
                    mem_write  = is_store;
                    state_next = mips_pkg::ST_MEM;
                end else begin
                    // addiu writes rt here, jr and nop just retire
                    pc_advance = 1'b1;
                    reg_write  = is_imm;
                    // a jr always runs its own delay slot first
                    state_next = is_jump ? mips_pkg::ST_FETCH : done_state;
                end
            end
            mips_pkg::ST_MEM: begin
                // stretched here by bus wait states
                if (mem_done) begin
                    if (is_store) begin
                        pc_advance = 1'b1;
                        state_next = done_state;
                    end else begin
                        state_next = mips_pkg::ST_WB;
                    end
                end
            end
            mips_pkg::ST_WB: begin
                reg_write     = 1'b1;
                reg_write_sel = 1'b1;
                pc_advance    = 1'b1;
                state_next    = done_state;
            end
            default: begin
                state_next = mips_pkg::ST_HALT;
            end
        endcase
        // bus timeout kills the instruction in flight
        if (bus_error) begin
            reg_write  = 1'b0;
            mem_start  = 1'b0;
            pc_advance = 1'b0;
            state_next = mips_pkg::ST_HALT;
        end
    end

    // halted is held high through reset, so active rises on the first edge
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= mips_pkg::ST_FETCH;
            halted <= 1'b1;
        end else begin
            state  <= state_next;
            halted <= (state_next == mips_pkg::ST_HALT);
        end
    end

endmodule

`default_nettype wire

//--- rtl/lwl_test_rom.sv
`timescale 1ns/1ps
`default_nettype none

module lwl_test_rom #(
    parameter int ROM_WORDS = 4096
) (
    input  logic [31:0] instr_address,
    output logic [31:0] instr_readdata
);

    localparam int ADDR_BITS = $clog2(ROM_WORDS);

    logic [31:0] rom [0:ROM_WORDS-1];

    // byte offset from the reset vector, then word index
    logic [31:0] rom_offset;
    logic [31:0] word_index;

    assign rom_offset = instr_address % mips_pkg::RESET_VECTOR;
    assign word_index = rom_offset >> 2;

    // i-type word: opcode | rs | rt | imm16
    function automatic logic [31:0] i_type(
        input mips_pkg::opcode_t op,
        input logic [4:0]        rs,
        input logic [4:0]        rt,
        input logic [15:0]       imm
    );
        return {op, rs, rt, imm};
    endfunction

    // r-type word under OP_SPECIAL, shamt always zero here
    function automatic logic [31:0] r_type(
        input logic [4:0]       rs,
        input logic [4:0]       rt,
        input logic [4:0]       rd,
        input mips_pkg::funct_t fn
    );
        return {mips_pkg::OP_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    initial begin
        // unused locations read as nop
        for (int i = 0; i < ROM_WORDS; i++) begin
            rom[i] = 32'h0000_0000;
        end

        // r2 = 0xffffffff, all ones so the kept low bytes show up
        rom[0] = i_type(mips_pkg::OP_ADDIU, 5'd0, 5'd2, 16'hFFFF);
        // r3 = 0xffff8cb3 after sign extension
        rom[1] = i_type(mips_pkg::OP_ADDIU, 5'd0, 5'd3, 16'h8CB3);
        // r4 = 100, base for the second load
        rom[2] = i_type(mips_pkg::OP_ADDIU, 5'd0, 5'd4, 16'd100);
        // lwl r2, 2(r0)  k = 2, keeps two low bytes of r2
        rom[3] = i_type(mips_pkg::OP_LWL, 5'd0, 5'd2, 16'd2);
        // lwl r3, 0(r4)  aligned, whole word replaces r3
        rom[4] = i_type(mips_pkg::OP_LWL, 5'd4, 5'd3, 16'd0);
        // store both results so the bus shows them
        rom[5] = i_type(mips_pkg::OP_SW, 5'd0, 5'd2, 16'd16);
        rom[6] = i_type(mips_pkg::OP_SW, 5'd0, 5'd3, 16'd20);
        // jr r0 ends the program after its delay slot
        rom[7] = r_type(5'd0, 5'd0, 5'd0, mips_pkg::FN_JR);
        // delay slot nop
        rom[8] = 32'h0000_0000;
    end

    // combinational read, fetch completes in one cycle
    assign instr_readdata = rom[word_index[ADDR_BITS-1:0]];

endmodule

`default_nettype wire

//--- rtl/mips_pkg.sv
`default_nettype none

package mips_pkg;

    // primary opcode field, instruction bits 31:26
    // only the subset needed by the lwl self-test decodes
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,
        OP_ADDIU   = 6'b001001,
        OP_LWL     = 6'b100010,
        OP_LW      = 6'b100011,
        OP_SW      = 6'b101011
    } opcode_t;

    // funct field of special (r-type) words, bits 5:0
    typedef enum logic [5:0] {
        FN_JR = 6'b001000
    } funct_t;

    // multicycle sequencer states
    typedef enum logic [2:0] {
        ST_FETCH,
        ST_EXEC,
        ST_MEM,
        ST_WB,
        ST_HALT
    } cpu_state_t;

    // first fetch address after reset (kseg1 boot rom)
    localparam logic [31:0] RESET_VECTOR = 32'hBFC0_0000;

    // register indices
    localparam logic [4:0] REG_ZERO = 5'd0;
    localparam logic [4:0] REG_V0   = 5'd2;

endpackage

`default_nettype wire
